// ==== all.f ====
+incdir+common
common/mem_pkg.sv
memory/line_ram.sv
src/mem_access_unit.sv
src/mem_subsystem.sv
sim/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mem_subsystem_tb -f all.f -Mdir obj_dir

output=$(./obj_dir/Vmem_subsystem_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1

// ==== sim/mem_subsystem_tb.sv ====
// Data memory subsystem testbench
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_subsystem_tb
  import mem_pkg::*;
();

  localparam logic [15:0] lfsr_seed = 16'd42886;
  localparam int random_ops = 344;
  localparam int timeout_cycles = 50;

  logic                  clock;
  logic                  reset;
  logic                  req_read;
  logic                  req_write;
  logic [`ADDR_BITS-1:0] req_addr;
  access_size_t          req_size;
  logic                  req_signed;
  logic [31:0]           req_wdata;
  logic                  busy;
  logic                  load_valid;
  logic [31:0]           load_data;
  logic                  store_done;
  logic                  misaligned;

  logic [15:0] lfsr;
  logic [7:0]  model_mem [`MEM_BYTES];
  int          op_count;

  mem_subsystem mem_subsystem_i (
    .clock      (clock),
    .reset      (reset),
    .req_read   (req_read),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_size   (req_size),
    .req_signed (req_signed),
    .req_wdata  (req_wdata),
    .busy       (busy),
    .load_valid (load_valid),
    .load_data  (load_data),
    .store_done (store_done),
    .misaligned (misaligned)
  );

  always #4 clock = ~clock;

  // taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic random_bits(input int count, output logic [31:0] value);
    value = 32'd0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", timeout_cycles, what);
    $display("Simulation failed");
    $fatal(1, "wait loop expired");
  endtask

  function automatic access_size_t pick_size(input logic [1:0] sel);
    return (sel == 2'd0) ? access_byte : (sel == 2'd1) ? access_half : access_word;
  endfunction

  function automatic logic [`ADDR_BITS-1:0] align_addr(input logic [`ADDR_BITS-1:0] addr,
                                                       input access_size_t size);
    case (size)
      access_byte: return addr;
      access_half: return {addr[`ADDR_BITS-1:1], 1'b0};
      default:     return {addr[`ADDR_BITS-1:2], 2'b00};
    endcase
  endfunction

  // little-endian bytes from the model, then extension.
  function automatic logic [31:0] model_load(input logic [`ADDR_BITS-1:0] addr,
                                             input access_size_t size, input logic sgn);
    int base;
    base = int'(addr);
    case (size)
      access_byte: return {{24{sgn & model_mem[base][7]}}, model_mem[base]};
      access_half: return {{16{sgn & model_mem[base+1][7]}}, model_mem[base+1], model_mem[base]};
      default: return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
    endcase
  endfunction

  // one request, its response checks and the model update.
  task automatic run_op(input logic is_store, input logic [`ADDR_BITS-1:0] addr,
                        input access_size_t size, input logic sgn, input logic [31:0] data);
    logic        fault;
    logic        got_fault;
    logic        got_load;
    logic        got_store;
    logic        saw_busy;
    logic [31:0] rdata;
    int          cycles;
    // an address that alignment would move is misaligned.
    fault = (align_addr(addr, size) != addr);
    cycles = 0;
    @(negedge clock);
    while (busy !== 1'b0) begin
      if (cycles == timeout_cycles) report_timeout("busy to drop");
      cycles++;
      @(negedge clock);
    end
    @(posedge clock);
    req_read   <= !is_store;
    req_write  <= is_store;
    req_addr   <= addr;
    req_size   <= size;
    req_signed <= sgn;
    req_wdata  <= data;
    @(posedge clock);
    req_read  <= 1'b0;
    req_write <= 1'b0;
    got_fault = 1'b0;
    got_load  = 1'b0;
    got_store = 1'b0;
    saw_busy  = 1'b0;
    rdata     = 32'd0;
    cycles    = 0;
    while (!(got_fault || got_load || got_store)) begin
      if (cycles == timeout_cycles) report_timeout("a completion pulse");
      cycles++;
      @(negedge clock);
      if (busy === 1'b1) saw_busy = 1'b1;
      got_fault = (misaligned === 1'b1);
      got_load  = (load_valid === 1'b1);
      got_store = (store_done === 1'b1);
      rdata     = load_data;
    end
    check_value(32'(got_fault), 32'(fault), "misaligned pulse");
    check_value(32'(got_load), 32'(!fault && !is_store), "load_valid pulse");
    check_value(32'(got_store), 32'(!fault && is_store), "store_done pulse");
    check_value(32'(busy), 32'd0, "busy at completion");
    check_value(32'(saw_busy), 32'(!fault), "busy during the request");
    if (fault) begin
      repeat (3) begin
        @(negedge clock);
        check_value(32'(load_valid | store_done), 32'd0, "pulse after misaligned request");
      end
    end else if (is_store) begin
      for (int i = 0; i < ((size == access_byte) ? 1 : (size == access_half) ? 2 : 4); i++) begin
        model_mem[int'(addr) + i] = data[8*i +: 8];
      end
    end else begin
      check_value(rdata, model_load(addr, size, sgn), $sformatf("load data at %h", addr));
    end
    op_count++;
  endtask

  initial begin
    logic [31:0]           bits;
    logic [31:0]           data;
    logic [`ADDR_BITS-1:0] addr;
    access_size_t          size;
    logic                  sgn;
    logic                  is_store;
    clock      = 1'b0;
    reset      = 1'b1;
    req_read   = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_size   = access_byte;
    req_signed = 1'b0;
    req_wdata  = 32'd0;
    lfsr       = lfsr_seed;
    op_count   = 0;
    for (int i = 0; i < `MEM_BYTES; i++) model_mem[i] = 8'h00;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    // cleared memory reads back as zero.
    for (int i = 0; i < 24; i++) begin
      random_bits(13, bits);
      size = pick_size(bits[12:11]);
      run_op(1'b0, align_addr(bits[`ADDR_BITS-1:0], size), size, bits[10], 32'd0);
    end

    // word round trip over the whole window.
    for (int a = 0; a < 64; a += 4) begin
      random_bits(32, data);
      run_op(1'b1, `ADDR_BITS'(a), access_word, 1'b0, data);
    end
    for (int a = 0; a < 64; a += 4) run_op(1'b0, `ADDR_BITS'(a), access_word, 1'b0, 32'd0);

    // mixed traffic, mostly in a 64-byte window.
    for (int i = 0; i < random_ops; i++) begin
      random_bits(7, bits);
      is_store = bits[6];
      size     = pick_size(bits[5:4]);
      sgn      = bits[3];
      if (bits[2:0] == 3'd0) begin
        random_bits(`ADDR_BITS, bits);
        addr = bits[`ADDR_BITS-1:0];
      end else begin
        random_bits(6, bits);
        addr = `ADDR_BITS'(bits[5:0]);
      end
      random_bits(3, bits);
      if (bits[2:0] != 3'd0) addr = align_addr(addr, size);
      random_bits(32, data);
      run_op(is_store, addr, size, sgn, data);
      // a rejected store must leave the word untouched.
      if (is_store && (align_addr(addr, size) != addr)) begin
        run_op(1'b0, align_addr(addr, access_word), access_word, 1'b0, 32'd0);
      end
    end

    $display("%0d operations checked", op_count);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
// Data memory subsystem top
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_subsystem
  import mem_pkg::*;
(
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  req_read,
  input  wire logic                  req_write,
  input  wire logic [`ADDR_BITS-1:0] req_addr,
  input  access_size_t               req_size,
  input  wire logic                  req_signed,
  input  wire logic [31:0]           req_wdata,
  output logic                       busy,
  output logic                       load_valid,
  output logic [31:0]                load_data,
  output logic                       store_done,
  output logic                       misaligned
);

  // line bus.
  logic                  line_read;
  logic                  line_write;
  logic [`ADDR_BITS-1:0] line_addr;
  mem_line_t             line_wdata;
  mem_line_t             line_rdata;
  logic                  line_ready;
  logic                  line_done;

  mem_access_unit mem_access_unit_i (
    .clock      (clock),
    .reset      (reset),
    .req_read   (req_read),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_size   (req_size),
    .req_signed (req_signed),
    .req_wdata  (req_wdata),
    .line_rdata (line_rdata),
    .line_ready (line_ready),
    .line_done  (line_done),
    .busy       (busy),
    .load_valid (load_valid),
    .load_data  (load_data),
    .store_done (store_done),
    .misaligned (misaligned),
    .line_read  (line_read),
    .line_write (line_write),
    .line_addr  (line_addr),
    .line_wdata (line_wdata)
  );

  line_ram line_ram_i (
    .clock      (clock),
    .reset      (reset),
    .line_read  (line_read),
    .line_write (line_write),
    .line_addr  (line_addr),
    .line_wdata (line_wdata),
    .line_rdata (line_rdata),
    .line_ready (line_ready),
    .line_done  (line_done)
  );

endmodule

`default_nettype wire

// ==== src/mem_access_unit.sv ====
// Sized load and store unit
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_access_unit
  import mem_pkg::*;
(
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  req_read,
  input  wire logic                  req_write,
  input  wire logic [`ADDR_BITS-1:0] req_addr,
  input  access_size_t               req_size,
  input  wire logic                  req_signed,
  input  wire logic [31:0]           req_wdata,
  input  mem_line_t                  line_rdata,
  input  wire logic                  line_ready,
  input  wire logic                  line_done,
  output logic                       busy,
  output logic                       load_valid,
  output logic [31:0]                load_data,
  output logic                       store_done,
  output logic                       misaligned,
  output logic                       line_read,
  output logic                       line_write,
  output logic [`ADDR_BITS-1:0]      line_addr,
  output mem_line_t                  line_wdata
);

  localparam int off_bits = `LINE_OFFSET_BITS;

  localparam logic [2:0] st_idle      = 3'd0;
  localparam logic [2:0] st_read      = 3'd1;
  localparam logic [2:0] st_wait_line = 3'd2;
  localparam logic [2:0] st_write     = 3'd3;
  localparam logic [2:0] st_wait_done = 3'd4;
  localparam logic [2:0] st_respond   = 3'd5;

  logic [2:0] state;

  // registered request.
  logic [`ADDR_BITS-1:0] addr_q;
  access_size_t          size_q;
  logic                  signed_q;
  logic                  write_q;
  logic [31:0]           wdata_q;

  logic                  accept;
  logic                  misaligned_now;
  logic                  fault_q;
  logic [off_bits-1:0]   line_off;
  logic [2:0]            access_bytes;
  logic [31:0]           load_value;
  mem_line_t             merged_line;

  assign busy = (state != st_idle) && (state != st_respond);
  assign accept = (req_read || req_write) && !busy;

  // half on an odd address, word off a 4-byte boundary.
  assign misaligned_now = ((req_size == access_half) && req_addr[0]) ||
                          ((req_size == access_word) && (req_addr[1:0] != 2'b00));

  assign line_off   = addr_q[off_bits-1:0];
  assign line_addr  = {addr_q[`ADDR_BITS-1:off_bits], {off_bits{1'b0}}};
  assign line_write = (state == st_write);
  assign load_valid = (state == st_respond) && !write_q;
  assign store_done = (state == st_respond) && write_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      line_read  <= 1'b0;
      fault_q    <= 1'b0;
      misaligned <= 1'b0;
    end else begin
      line_read  <= 1'b0;
      fault_q    <= 1'b0;
      misaligned <= fault_q;
      case (state)
        st_idle, st_respond: begin
          state <= st_idle;
          if (accept) begin
            // a faulting request is reported and dropped.
            if (misaligned_now) begin
              fault_q <= 1'b1;
            end else begin
              state <= st_read;
            end
          end
        end
        st_read: begin
          line_read <= 1'b1;
          state     <= st_wait_line;
        end
        st_wait_line: begin
          if (line_ready) begin
            state <= write_q ? st_write : st_respond;
          end
        end
        st_write: begin
          state <= st_wait_done;
        end
        st_wait_done: begin
          if (line_done) begin
            state <= st_respond;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // request capture and line payload.
  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q   <= req_addr;
      size_q   <= req_size;
      signed_q <= req_signed;
      write_q  <= req_write;
      wdata_q  <= req_wdata;
    end
    if ((state == st_wait_line) && line_ready) begin
      load_data  <= load_value;
      line_wdata <= merged_line;
    end
  end

  always_comb begin
    case (size_q)
      access_byte: access_bytes = 3'd1;
      access_half: access_bytes = 3'd2;
      default:     access_bytes = 3'd4;
    endcase
  end

  // load path: word from the word view, then narrow and extend.
  always_comb begin
    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  byte_val;
    word     = line_rdata.words[line_off[off_bits-1:2]];
    half     = line_off[1] ? word[31:16] : word[15:0];
    byte_val = word[{line_off[1:0], 3'b000} +: 8];
    case (size_q)
      access_byte: load_value = {{24{signed_q & byte_val[7]}}, byte_val};
      access_half: load_value = {{16{signed_q & half[15]}}, half};
      default:     load_value = word;
    endcase
  end

  // store path: patch only the addressed bytes of the fetched line.
  always_comb begin
    logic [off_bits-1:0] idx;
    merged_line = line_rdata;
    for (int i = 0; i < 4; i++) begin
      idx = line_off + off_bits'(i);
      if (i < int'(access_bytes)) begin
        merged_line.bytes[idx] = wdata_q[8*i +: 8];
      end
    end
  end

  // requesters wait for busy to drop.
  a_no_req_busy : assert property (
    @(posedge clock) disable iff (reset) busy |-> !(req_read || req_write)
  );

  a_one_req : assert property (
    @(posedge clock) disable iff (reset) !(req_read && req_write)
  );

endmodule

`default_nettype wire

// ==== memory/line_ram.sv ====
// Line-wide byte memory
`default_nettype none
`timescale 1ns/1ps

`include "mem_defs.svh"

module line_ram
  import mem_pkg::*;
(
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  line_read,
  input  wire logic                  line_write,
  input  wire logic [`ADDR_BITS-1:0] line_addr,
  input  mem_line_t                  line_wdata,
  output mem_line_t                  line_rdata,
  output logic                       line_ready,
  output logic                       line_done
);

  localparam int off_bits = `LINE_OFFSET_BITS;

  logic [7:0] mem_bytes [`MEM_BYTES];

  // line number, low offset bits dropped.
  logic [`ADDR_BITS-off_bits-1:0] line_index;

  assign line_index = line_addr[`ADDR_BITS-1:off_bits];

  // array contents and write path.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MEM_BYTES; i++) begin
        mem_bytes[i] <= 8'h00;
      end
    end else if (line_write) begin
      for (int i = 0; i < `LINE_BYTES; i++) begin
        mem_bytes[{line_index, off_bits'(i)}] <= line_wdata.bytes[i];
      end
    end
  end

  // read data, held until the next read.
  always_ff @(posedge clock) begin
    if (line_read) begin
      for (int i = 0; i < `LINE_BYTES; i++) begin
        line_rdata.bytes[i] <= mem_bytes[{line_index, off_bits'(i)}];
      end
    end
  end

  // completion pulses, one cycle after the strobe.
  always_ff @(posedge clock) begin
    if (reset) begin
      line_ready <= 1'b0;
      line_done  <= 1'b0;
    end else begin
      line_ready <= line_read;
      line_done  <= line_write;
    end
  end

  // the bus master issues one transfer at a time.
  a_one_strobe : assert property (
    @(posedge clock) disable iff (reset) !(line_read && line_write)
  );

endmodule

`default_nettype wire

// ==== common/mem_pkg.sv ====
// Memory subsystem types
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

  // size of a processor load or store.
  typedef enum logic [1:0] {
    access_byte = 2'd0,
    access_half = 2'd1,
    access_word = 2'd2
  } access_size_t;

  // one bus line, seen as bytes or as little-endian words.
  typedef union packed {
    logic [`LINE_BYTES-1:0][7:0] bytes;
    logic [`LINE_WORDS-1:0][31:0] words;
  } mem_line_t;

endpackage

`default_nettype wire

// ==== common/mem_defs.svh ====
// Memory geometry macros
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// total memory size in bytes.
`define MEM_BYTES 1024

// byte address width.
`define ADDR_BITS 10

// one line bus transfer.
`define LINE_BYTES 16
`define LINE_BITS 128

// byte-in-line offset width.
`define LINE_OFFSET_BITS 4

// 32-bit words per line.
`define LINE_WORDS 4

`endif
